//--- chan_pkg.sv
`default_nettype none

package chan_pkg;

  // data word and address
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;

  // inter-cpu message code
  typedef logic [7:0] cpu_msg_t;

  // processor state code
  typedef logic [7:0] state_t;

  // command code field, bits 31:28
  typedef logic [3:0] cmd_code_t;

  // channel operation classes
  typedef enum logic [1:0] {
    OP_GET,
    OP_SET,
    OP_CONV,
    OP_NONE
  } chan_op_e;

  // channel command
  localparam cmd_code_t CMD_CHN = 4'hA;

  // processor states seen by the controller
  localparam state_t ST_ALU_BEGIN  = 8'h03;
  localparam state_t ST_FINISH_END = 8'h0F;

  // outgoing requests
  localparam cpu_msg_t MSG_CHAN_GET       = 8'h20;
  localparam cpu_msg_t MSG_CHAN_SET       = 8'h21;
  localparam cpu_msg_t MSG_THREAD_ADDRESS = 8'h22;

  // replies from the cpu side
  localparam cpu_msg_t MSG_OP_ACCEPTED = 8'h30;
  localparam cpu_msg_t MSG_NO_RESULTS  = 8'h31;
  localparam cpu_msg_t MSG_RES_RD      = 8'h32;
  localparam cpu_msg_t MSG_RES_WR      = 8'h33;

  // thread header sits below both base addresses
  localparam data_t THREAD_HEADER_SPACE = 32'd16;

endpackage

`default_nettype wire

//--- chan_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module chan_cmd_decode
  import chan_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  wire          clk,
  input  wire          rst,
  input  wire data_t   command_i,
  input  wire state_t  state_i,
  input  wire          disp_online_i,
  input  wire data_t   src0_i,
  input  wire data_t   src1_i,
  input  wire          op_done_i,
  output logic         op_start_o,
  output chan_op_e     op_kind_o,
  output data_t        op_src0_o,
  output data_t        op_src1_o
);

  cmd_code_t         cmd_code;
  // register enables, a pair of ones marks an unused slot
  logic              d_en;
  logic              s0_en;
  logic              s1_en;
  chan_op_e          kind_dec;
  logic              eligible;
  // one operation in flight
  logic              busy;
  logic [DATA_W-1:0] src0_r;
  logic [DATA_W-1:0] src1_r;

  assign cmd_code = command_i[31:28];
  assign s1_en    = !(command_i[21] & command_i[20]);
  assign s0_en    = !(command_i[23] & command_i[22]);
  assign d_en     = !(command_i[25] & command_i[24]);

  // dst, src0, src1 pattern picks the operation
  always_comb begin
    case ({d_en, s0_en, s1_en})
      3'b110:  kind_dec = OP_GET;
      3'b011:  kind_dec = OP_SET;
      3'b101:  kind_dec = OP_CONV;
      default: kind_dec = OP_NONE;
    endcase
  end

  // channel command at alu begin with dispatcher up
  assign eligible = (state_i == ST_ALU_BEGIN) && (cmd_code == CMD_CHN) &&
                    disp_online_i && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      op_start_o <= 1'b0;
      op_kind_o  <= OP_NONE;
    end else begin
      op_start_o <= eligible;
      if (eligible) begin
        busy      <= 1'b1;
        op_kind_o <= kind_dec;
      end else if (op_done_i) begin
        // reply stage finished, accept the next command
        busy <= 1'b0;
      end
    end
  end

  // operands held for the whole operation
  always_ff @(posedge clk) begin
    if (eligible) begin
      src0_r <= src0_i;
      src1_r <= src1_i;
    end
  end

  assign op_src0_o = src0_r;
  assign op_src1_o = src1_r;

  // no second start before the reply stage reports done
  a_single_op : assert property (@(posedge clk) disable iff (rst)
    op_start_o |=> (!op_start_o until op_done_i));

endmodule

`default_nettype wire

//--- chan_msg_issue.sv
`timescale 1ns/1ps
`default_nettype none

module chan_msg_issue
  import chan_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            op_start_i,
  input  wire chan_op_e  op_kind_i,
  input  wire data_t     op_src0_i,
  input  wire data_t     op_src1_i,
  input  wire addr_t     base_addr_i,
  input  wire data_t     base_addr_data_i,
  output cpu_msg_t       cpu_msg_o,
  output data_t          data_o,
  output addr_t          addr_o,
  output logic           cpu_msg_pulse_o,
  output logic           chan_msg_strb_o,
  output logic           wait_go_o,
  output chan_op_e       wait_kind_o
);

  typedef enum logic [1:0] {
    IDLE,
    SEND_CHAN,
    SEND_THREAD
  } issue_state_e;

  issue_state_e      state_q;
  // message payload is only meaningful during a pulse
  cpu_msg_t          msg_r;
  logic [DATA_W-1:0] data_r;
  addr_t             addr_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= IDLE;
      cpu_msg_pulse_o <= 1'b0;
      chan_msg_strb_o <= 1'b0;
      wait_go_o       <= 1'b0;
      wait_kind_o     <= OP_NONE;
    end else begin
      // pulses last one cycle
      cpu_msg_pulse_o <= 1'b0;
      chan_msg_strb_o <= 1'b0;
      wait_go_o       <= 1'b0;
      case (state_q)
        IDLE: begin
          if (op_start_i) begin
            if (op_kind_i == OP_GET || op_kind_i == OP_SET) begin
              // first message carries the strobe
              cpu_msg_pulse_o <= 1'b1;
              chan_msg_strb_o <= 1'b1;
              state_q         <= SEND_CHAN;
            end else begin
              // convert and illegal go straight to the reply stage
              wait_go_o   <= 1'b1;
              wait_kind_o <= op_kind_i;
            end
          end
        end
        SEND_CHAN: begin
          // thread address follows and hands over to the reply stage
          cpu_msg_pulse_o <= 1'b1;
          wait_go_o       <= 1'b1;
          wait_kind_o     <= op_kind_i;
          state_q         <= SEND_THREAD;
        end
        SEND_THREAD: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // payload loads alongside the pulse
  always_ff @(posedge clk) begin
    if (state_q == IDLE && op_start_i) begin
      addr_r <= op_src0_i;
      if (op_kind_i == OP_SET) begin
        msg_r  <= MSG_CHAN_SET;
        data_r <= op_src1_i;
      end else begin
        msg_r  <= MSG_CHAN_GET;
        data_r <= '0;
      end
    end else if (state_q == SEND_CHAN) begin
      msg_r  <= MSG_THREAD_ADDRESS;
      addr_r <= base_addr_i - THREAD_HEADER_SPACE;
      data_r <= base_addr_data_i - THREAD_HEADER_SPACE;
    end
  end

  // bus idles at zero between pulses
  assign cpu_msg_o = cpu_msg_pulse_o ? msg_r : '0;
  assign data_o    = cpu_msg_pulse_o ? data_r : '0;
  assign addr_o    = cpu_msg_pulse_o ? addr_r : '0;

  // a new operation only arrives while both messages are out
  a_start_idle : assert property (@(posedge clk) disable iff (rst)
    op_start_i |-> state_q == IDLE);

endmodule

`default_nettype wire

//--- chan_reply_eval.sv
`timescale 1ns/1ps
`default_nettype none

module chan_reply_eval
  import chan_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            wait_go_i,
  input  wire chan_op_e  wait_kind_i,
  input  wire cpu_msg_t  cpu_msg_i,
  input  wire data_t     data_i,
  input  wire data_t     src1_i,
  input  wire data_t     base_addr_data_i,
  input  wire state_t    state_i,
  output data_t          dst_o,
  output logic           next_state_o,
  output logic           chan_escape_o,
  output logic           chan_wait_next_time_o,
  output logic           op_done_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_REPLY,
    FINISH
  } reply_state_e;

  reply_state_e      state_q;
  chan_op_e          kind_r;
  logic [DATA_W-1:0] dst_r;
  // channel number conversion
  logic [DATA_W-1:0] conv_sum;

  assign conv_sum = src1_i + base_addr_data_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q               <= IDLE;
      kind_r                <= OP_NONE;
      dst_r                 <= '0;
      next_state_o          <= 1'b0;
      op_done_o             <= 1'b0;
      chan_escape_o         <= 1'b0;
      chan_wait_next_time_o <= 1'b0;
    end else begin
      next_state_o <= 1'b0;
      op_done_o    <= 1'b0;
      // processor acknowledged the escape or wait
      if (state_i == ST_FINISH_END) begin
        chan_escape_o         <= 1'b0;
        chan_wait_next_time_o <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (wait_go_i) begin
            kind_r <= wait_kind_i;
            case (wait_kind_i)
              OP_GET, OP_SET: begin
                state_q <= WAIT_REPLY;
              end
              OP_CONV: begin
                dst_r        <= conv_sum;
                next_state_o <= 1'b1;
                op_done_o    <= 1'b1;
              end
              default: begin
                // illegal pattern, done with dst untouched
                next_state_o <= 1'b1;
                op_done_o    <= 1'b1;
              end
            endcase
          end
        end
        WAIT_REPLY: begin
          // unrelated codes are ignored
          case (cpu_msg_i)
            MSG_OP_ACCEPTED: begin
              chan_escape_o <= 1'b1;
              state_q       <= FINISH;
            end
            MSG_NO_RESULTS: begin
              chan_wait_next_time_o <= 1'b1;
              state_q               <= FINISH;
            end
            MSG_RES_RD: begin
              if (kind_r == OP_GET) begin
                dst_r        <= data_i;
                next_state_o <= 1'b1;
                op_done_o    <= 1'b1;
                state_q      <= IDLE;
              end
            end
            MSG_RES_WR: begin
              if (kind_r == OP_SET) begin
                next_state_o <= 1'b1;
                op_done_o    <= 1'b1;
                state_q      <= IDLE;
              end
            end
            default: begin
              state_q <= WAIT_REPLY;
            end
          endcase
        end
        FINISH: begin
          // flag is up, release the processor
          next_state_o <= 1'b1;
          op_done_o    <= 1'b1;
          state_q      <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign dst_o = dst_r;

  // back-to-back completions would mean two ops in flight
  a_next_state_single : assert property (@(posedge clk) disable iff (rst)
    next_state_o |=> !next_state_o);

endmodule

`default_nettype wire

//--- chan_ctlr.sv
`timescale 1ns/1ps
`default_nettype none

module chan_ctlr
  import chan_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  wire            clk,
  input  wire            rst,
  input  wire data_t     command_i,
  input  wire state_t    state_i,
  input  wire data_t     src1_i,
  input  wire data_t     src0_i,
  input  wire addr_t     base_addr_i,
  input  wire data_t     base_addr_data_i,
  input  wire            disp_online_i,
  input  wire cpu_msg_t  cpu_msg_i,
  input  wire data_t     data_i,
  output data_t          dst_o,
  output cpu_msg_t       cpu_msg_o,
  output data_t          data_o,
  output addr_t          addr_o,
  output logic           cpu_msg_pulse_o,
  output logic           chan_msg_strb_o,
  output logic           next_state_o,
  output logic           chan_escape_o,
  output logic           chan_wait_next_time_o
);

  // decode to issue
  logic     op_start;
  chan_op_e op_kind;
  data_t    op_src0;
  data_t    op_src1;
  // issue to reply
  logic     wait_go;
  chan_op_e wait_kind;
  // reply back to decode
  logic     op_done;

  // datapath registers must fit the bus words
  if (DATA_W != $bits(data_t)) begin : g_width_check
    $error("chan_ctlr: DATA_W must equal the data word width");
  end

  chan_cmd_decode #(
    .DATA_W(DATA_W)
  ) u_decode (
    .clk          (clk),
    .rst          (rst),
    .command_i    (command_i),
    .state_i      (state_i),
    .disp_online_i(disp_online_i),
    .src0_i       (src0_i),
    .src1_i       (src1_i),
    .op_done_i    (op_done),
    .op_start_o   (op_start),
    .op_kind_o    (op_kind),
    .op_src0_o    (op_src0),
    .op_src1_o    (op_src1)
  );

  chan_msg_issue #(
    .DATA_W(DATA_W)
  ) u_issue (
    .clk             (clk),
    .rst             (rst),
    .op_start_i      (op_start),
    .op_kind_i       (op_kind),
    .op_src0_i       (op_src0),
    .op_src1_i       (op_src1),
    .base_addr_i     (base_addr_i),
    .base_addr_data_i(base_addr_data_i),
    .cpu_msg_o       (cpu_msg_o),
    .data_o          (data_o),
    .addr_o          (addr_o),
    .cpu_msg_pulse_o (cpu_msg_pulse_o),
    .chan_msg_strb_o (chan_msg_strb_o),
    .wait_go_o       (wait_go),
    .wait_kind_o     (wait_kind)
  );

  // convert uses the latched src1, not the live port
  chan_reply_eval #(
    .DATA_W(DATA_W)
  ) u_reply (
    .clk                  (clk),
    .rst                  (rst),
    .wait_go_i            (wait_go),
    .wait_kind_i          (wait_kind),
    .cpu_msg_i            (cpu_msg_i),
    .data_i               (data_i),
    .src1_i               (op_src1),
    .base_addr_data_i     (base_addr_data_i),
    .state_i              (state_i),
    .dst_o                (dst_o),
    .next_state_o         (next_state_o),
    .chan_escape_o        (chan_escape_o),
    .chan_wait_next_time_o(chan_wait_next_time_o),
    .op_done_o            (op_done)
  );

endmodule

`default_nettype wire

//--- chan_ctlr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module chan_ctlr_checker
  import chan_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  // expected operation from the testbench model
  input  wire            exp_valid_i,
  input  wire chan_op_e  exp_kind_i,
  // dut inputs
  input  wire state_t    state_i,
  input  wire data_t     src0_i,
  input  wire data_t     src1_i,
  input  wire addr_t     base_addr_i,
  input  wire data_t     base_addr_data_i,
  input  wire cpu_msg_t  reply_msg_i,
  input  wire data_t     reply_data_i,
  // dut outputs
  input  wire data_t     dst_i,
  input  wire cpu_msg_t  dut_msg_i,
  input  wire data_t     dut_data_i,
  input  wire addr_t     dut_addr_i,
  input  wire            msg_pulse_i,
  input  wire            msg_strb_i,
  input  wire            next_state_i,
  input  wire            escape_i,
  input  wire            wait_next_i,
  output int             err_count_o,
  output int             op_count_o,
  output int             pass_count_o
);

  int       op_errs = 0;
  int       bus_errs = 0;
  int       errs_before;
  string    test_name;
  chan_op_e kind;
  data_t    src0;
  data_t    src1;
  data_t    dst_model;
  logic     esc_model;
  logic     wait_model;
  cpu_msg_t reply_code;
  data_t    reply_data;

  assign err_count_o = op_errs + bus_errs;

  function automatic string kind_name(input chan_op_e k);
    case (k)
      OP_GET:  return "get";
      OP_SET:  return "set";
      OP_CONV: return "conv";
      default: return "illegal";
    endcase
  endfunction

  task automatic check_word(input string what, input data_t exp_v, input data_t act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      op_errs++;
    end
  endtask

  task automatic check_code(input string what, input cpu_msg_t exp_v, input cpu_msg_t act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      op_errs++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp_v, act_v);
      op_errs++;
    end
  endtask

  // bus reads zero between pulses and the strobe needs a pulse
  always @(negedge clk) begin
    if (!rst && !msg_pulse_i) begin
      if (dut_msg_i !== '0 || dut_data_i !== '0 || dut_addr_i !== '0 || msg_strb_i) begin
        $display("FAIL bus_idle msg/data/addr/strb: expected 0/0/0/0, actual %h/%h/%h/%b",
                 dut_msg_i, dut_data_i, dut_addr_i, msg_strb_i);
        bus_errs++;
      end
    end
  end

  initial begin
    op_count_o   = 0;
    pass_count_o = 0;
    dst_model    = '0;
    forever begin
      @(negedge clk);
      if (!rst && exp_valid_i) begin
        kind        = exp_kind_i;
        src0        = src0_i;
        src1        = src1_i;
        esc_model   = 1'b0;
        wait_model  = 1'b0;
        errs_before = op_errs;
        test_name   = $sformatf("op%0d_%s", op_count_o, kind_name(kind));
        // nothing visible during the decode cycle
        @(negedge clk);
        check_bit("pulse at decode", 1'b0, msg_pulse_i);
        check_bit("next_state at decode", 1'b0, next_state_i);
        if (kind == OP_GET || kind == OP_SET) begin
          @(negedge clk);
          check_bit("first pulse", 1'b1, msg_pulse_i);
          check_bit("first strobe", 1'b1, msg_strb_i);
          check_code("first msg", (kind == OP_GET) ? MSG_CHAN_GET : MSG_CHAN_SET, dut_msg_i);
          check_word("first addr", src0, dut_addr_i);
          if (kind == OP_SET)
            check_word("first data", src1, dut_data_i);
          // thread address sits header space below both bases
          @(negedge clk);
          check_bit("thread pulse", 1'b1, msg_pulse_i);
          check_bit("thread strobe", 1'b0, msg_strb_i);
          check_code("thread msg", MSG_THREAD_ADDRESS, dut_msg_i);
          check_word("thread addr", base_addr_i - THREAD_HEADER_SPACE, dut_addr_i);
          check_word("thread data", base_addr_data_i - THREAD_HEADER_SPACE, dut_data_i);
          @(negedge clk);
          while (reply_msg_i == '0) begin
            check_bit("next_state before reply", 1'b0, next_state_i);
            @(negedge clk);
          end
          reply_code = reply_msg_i;
          reply_data = reply_data_i;
          @(negedge clk);
          if (reply_code == MSG_RES_RD || reply_code == MSG_RES_WR) begin
            check_bit("next_state after result", 1'b1, next_state_i);
            if (reply_code == MSG_RES_RD)
              dst_model = reply_data;
          end else begin
            // flag rises first and the release follows a cycle later
            esc_model  = (reply_code == MSG_OP_ACCEPTED);
            wait_model = (reply_code == MSG_NO_RESULTS);
            check_bit("escape flag", esc_model, escape_i);
            check_bit("wait flag", wait_model, wait_next_i);
            check_bit("next_state with flag", 1'b0, next_state_i);
            @(negedge clk);
            check_bit("next_state after flag", 1'b1, next_state_i);
          end
        end else begin
          @(negedge clk);
          check_bit("next_state early", 1'b0, next_state_i);
          check_bit("pulse early", 1'b0, msg_pulse_i);
          @(negedge clk);
          check_bit("next_state", 1'b1, next_state_i);
          check_bit("pulse on no-message op", 1'b0, msg_pulse_i);
          if (kind == OP_CONV)
            dst_model = src1 + base_addr_data_i;
        end
        check_word("dst", dst_model, dst_i);
        // flags stay up until the processor reaches finish end
        @(negedge clk);
        while (state_i != ST_FINISH_END)
          @(negedge clk);
        check_bit("escape held", esc_model, escape_i);
        check_bit("wait held", wait_model, wait_next_i);
        @(negedge clk);
        check_bit("escape after finish", 1'b0, escape_i);
        check_bit("wait after finish", 1'b0, wait_next_i);
        op_count_o++;
        if (op_errs == errs_before) begin
          pass_count_o++;
          $display("test %s passed", test_name);
        end else begin
          $display("test %s failed with %0d errors", test_name, op_errs - errs_before);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- chan_ctlr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chan_ctlr_tb
  import chan_pkg::*;
;

  localparam int NUM_OPS = 40;
  // about 30 cycles per op over 40 ops plus reset and margin
  localparam int TIMEOUT_CYCLES = 1500;
  localparam logic [31:0] SEED = 32'hda134d44;
  // any state other than alu begin and finish end
  localparam state_t ST_RUN = 8'h05;

  logic clk = 1'b0;
  logic rst;
  data_t command_i;
  state_t state_i;
  data_t src0_i;
  data_t src1_i;
  addr_t base_addr_i;
  data_t base_addr_data_i;
  logic disp_online_i;
  cpu_msg_t cpu_msg_i;
  data_t data_i;
  data_t dst_o;
  cpu_msg_t cpu_msg_o;
  data_t data_o;
  addr_t addr_o;
  logic cpu_msg_pulse_o;
  logic chan_msg_strb_o;
  logic next_state_o;
  logic chan_escape_o;
  logic chan_wait_next_time_o;

  // model of the current operation
  logic exp_valid;
  chan_op_e exp_kind;
  cpu_msg_t reply_code;
  int reply_delay;
  data_t reply_data;
  int err_count;
  int op_count;
  int pass_count;
  int cycle_count = 0;
  logic [31:0] seed_sink;

  always #10 clk = ~clk;

  chan_ctlr #(
    .DATA_W(32)
  ) dut (
    .clk(clk), .rst(rst), .command_i(command_i), .state_i(state_i),
    .src1_i(src1_i), .src0_i(src0_i), .base_addr_i(base_addr_i),
    .base_addr_data_i(base_addr_data_i), .disp_online_i(disp_online_i),
    .cpu_msg_i(cpu_msg_i), .data_i(data_i), .dst_o(dst_o), .cpu_msg_o(cpu_msg_o),
    .data_o(data_o), .addr_o(addr_o), .cpu_msg_pulse_o(cpu_msg_pulse_o),
    .chan_msg_strb_o(chan_msg_strb_o), .next_state_o(next_state_o),
    .chan_escape_o(chan_escape_o), .chan_wait_next_time_o(chan_wait_next_time_o)
  );

  chan_ctlr_checker u_checker (
    .clk(clk), .rst(rst), .exp_valid_i(exp_valid), .exp_kind_i(exp_kind),
    .state_i(state_i), .src0_i(src0_i), .src1_i(src1_i), .base_addr_i(base_addr_i),
    .base_addr_data_i(base_addr_data_i), .reply_msg_i(cpu_msg_i), .reply_data_i(data_i),
    .dst_i(dst_o), .dut_msg_i(cpu_msg_o), .dut_data_i(data_o), .dut_addr_i(addr_o),
    .msg_pulse_i(cpu_msg_pulse_o), .msg_strb_i(chan_msg_strb_o),
    .next_state_i(next_state_o), .escape_i(chan_escape_o),
    .wait_next_i(chan_wait_next_time_o), .err_count_o(err_count),
    .op_count_o(op_count), .pass_count_o(pass_count)
  );

  // enabled slot gets any pair but 11
  function automatic logic [1:0] enable_pair(input logic enabled);
    logic [31:0] r;
    r = $urandom % 3;
    if (enabled)
      return r[1:0];
    return 2'b11;
  endfunction

  // pattern bits are dst, src0, src1 enables
  function automatic data_t build_command(input logic [2:0] pattern);
    data_t cmd;
    cmd = $urandom;
    cmd[31:28] = CMD_CHN;
    cmd[25:24] = enable_pair(pattern[2]);
    cmd[23:22] = enable_pair(pattern[1]);
    cmd[21:20] = enable_pair(pattern[0]);
    return cmd;
  endfunction

  task automatic run_op();
    logic [31:0] pick;
    logic [31:0] sel;
    logic [2:0] pattern;
    chan_op_e kind;
    pick = $urandom % 10;
    if (pick < 3) begin
      kind = OP_GET;
      pattern = 3'b110;
    end else if (pick < 6) begin
      kind = OP_SET;
      pattern = 3'b011;
    end else if (pick < 8) begin
      kind = OP_CONV;
      pattern = 3'b101;
    end else begin
      kind = OP_NONE;
      sel = $urandom % 5;
      case (sel)
        0: pattern = 3'b000;
        1: pattern = 3'b001;
        2: pattern = 3'b010;
        3: pattern = 3'b100;
        default: pattern = 3'b111;
      endcase
    end
    // legal reply for get or set
    sel = $urandom % 3;
    case (sel)
      0: reply_code = (kind == OP_GET) ? MSG_RES_RD : MSG_RES_WR;
      1: reply_code = MSG_OP_ACCEPTED;
      default: reply_code = MSG_NO_RESULTS;
    endcase
    reply_delay = $urandom % 9;
    reply_data = $urandom;
    @(posedge clk);
    command_i <= build_command(pattern);
    state_i <= ST_ALU_BEGIN;
    src0_i <= $urandom;
    src1_i <= $urandom;
    base_addr_i <= $urandom;
    base_addr_data_i <= $urandom;
    exp_valid <= 1'b1;
    exp_kind <= kind;
    // alu begin for a single cycle only
    @(posedge clk);
    state_i <= ST_RUN;
    exp_valid <= 1'b0;
    @(negedge clk);
    while (!next_state_o)
      @(negedge clk);
    @(posedge clk);
    state_i <= ST_FINISH_END;
    @(posedge clk);
    state_i <= ST_RUN;
    repeat (2) @(posedge clk);
  endtask

  // answers after the thread address message
  initial begin
    cpu_msg_i <= '0;
    data_i <= '0;
    forever begin
      @(negedge clk);
      if (cpu_msg_pulse_o && cpu_msg_o == MSG_THREAD_ADDRESS) begin
        @(posedge clk);
        repeat (reply_delay) @(posedge clk);
        cpu_msg_i <= reply_code;
        data_i <= reply_data;
        @(posedge clk);
        cpu_msg_i <= '0;
        data_i <= '0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    rst <= 1'b1;
    command_i <= '0;
    state_i <= ST_RUN;
    src0_i <= '0;
    src1_i <= '0;
    base_addr_i <= '0;
    base_addr_data_i <= '0;
    disp_online_i <= 1'b1;
    exp_valid <= 1'b0;
    exp_kind <= OP_NONE;
    seed_sink = $urandom(SEED);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_OPS; i++)
      run_op();
    repeat (4) @(posedge clk);
    $display("ops %0d, passed %0d, failed %0d, errors %0d",
             op_count, pass_count, op_count - pass_count, err_count);
    if (err_count == 0 && op_count == NUM_OPS) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- chan_ctlr.f
chan_pkg.sv
chan_cmd_decode.sv
chan_msg_issue.sv
chan_reply_eval.sv
chan_ctlr.sv
chan_ctlr_checker.sv
chan_ctlr_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the channel controller testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module chan_ctlr_tb \
  -f chan_ctlr.f \
  -o chan_ctlr_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/chan_ctlr_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0
